//--- design/bg_load_requester.sv
// background load requester: APB writes of background indices with one pending slot
`timescale 1ns/1ps

module bg_load_requester #(
	parameter int unsigned NUM_MAPS = 3
) (
	input  logic              Clk,
	input  logic              rst,
	input  game_pkg::bg_req_t bg_req,
	input  logic [3:0]        map_idx,
	output logic [11:0]       paddr,
	output logic              psel,
	output logic              penable,
	output logic              pwrite,
	output logic [3:0]        pwdata,
	input  logic              pready,
	input  logic              pslverr,
	output logic [7:0]        err_count
);

	typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_t;

	apb_state_t state;
	logic [3:0] req_idx;
	logic [3:0] pending_idx;
	logic       pending_valid;
	logic       xfer_done;
	logic       take_req;
	logic       take_pending;
	logic       store_pending;

	// map choice is captured here, at request time
	always_comb
	begin
		case (bg_req.kind)
			game_pkg::bg_map:      req_idx = map_idx;
			game_pkg::bg_blue_win: req_idx = 4'(NUM_MAPS);
			game_pkg::bg_red_win:  req_idx = 4'(NUM_MAPS + 1);
			default:               req_idx = 4'(NUM_MAPS + 2);
		endcase
	end

	assign xfer_done = (state == apb_access) && pready;
	assign take_req = bg_req.valid && ((state == apb_idle) || xfer_done);
	assign take_pending = xfer_done && !bg_req.valid && pending_valid;
	// newest request overwrites the slot while the bus is busy
	assign store_pending = bg_req.valid && (state != apb_idle) && !xfer_done;

	assign psel = (state != apb_idle);
	assign penable = (state == apb_access);
	assign pwrite = 1'b1;
	assign paddr = game_pkg::BG_REG_ADDR;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= apb_idle;
			pending_valid <= 1'b0;
			err_count <= '0;
		end
		else
		begin
			case (state)
				apb_idle:   if (take_req) state <= apb_setup;
				apb_setup:  state <= apb_access;
				apb_access:
					if (xfer_done)
						state <= (take_req || take_pending) ? apb_setup : apb_idle;
				default:    state <= apb_idle;
			endcase
			if (store_pending)
				pending_valid <= 1'b1;
			else if (xfer_done)
				pending_valid <= 1'b0;
			// saturating count of error responses
			if (xfer_done && pslverr && (err_count != 8'hff))
				err_count <= err_count + 8'd1;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (take_req)
			pwdata <= req_idx;
		else if (take_pending)
			pwdata <= pending_idx;
		if (store_pending)
			pending_idx <= req_idx;
	end

	enable_needs_sel: assert property (@(posedge Clk) disable iff (rst)
		penable |-> psel);

	// address and data held from setup until the pready edge
	xfer_stable: assert property (@(posedge Clk) disable iff (rst)
		(psel && !xfer_done) |=> ($stable(pwdata) && $stable(paddr)));

endmodule

//--- design/game_control_top.sv
// game controller top: key decoder, state machine, map selector and APB requester
`timescale 1ns/1ps

module game_control_top #(
	parameter int unsigned NUM_MAPS = 3
) (
	input  logic                  Clk,
	input  logic                  rst,
	input  logic                  reset_game,
	input  logic                  reset_round,
	input  logic                  blue_win,
	input  logic                  red_win,
	input  logic [7:0]            scan_code,
	output game_pkg::game_state_t game_state,
	output logic [11:0]           paddr,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [3:0]            pwdata,
	input  logic                  pready,
	input  logic                  pslverr,
	output logic [7:0]            err_count
);

	game_pkg::key_event_t key_event;
	game_pkg::bg_req_t    bg_req;
	logic [3:0]           map_idx;

	key_event_decoder u_decoder (.Clk(Clk), .rst(rst), .scan_code(scan_code),
		.key_event(key_event));

	game_state_fsm u_fsm (.Clk(Clk), .rst(rst), .reset_game(reset_game),
		.reset_round(reset_round), .blue_win(blue_win), .red_win(red_win),
		.key_event(key_event), .game_state(game_state), .bg_req(bg_req));

	map_selector #(.NUM_MAPS(NUM_MAPS)) u_selector (.Clk(Clk), .rst(rst),
		.key_event(key_event), .game_state(game_state), .map_idx(map_idx));

	bg_load_requester #(.NUM_MAPS(NUM_MAPS)) u_requester (.Clk(Clk), .rst(rst),
		.bg_req(bg_req), .map_idx(map_idx), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .pready(pready),
		.pslverr(pslverr), .err_count(err_count));

endmodule

//--- design/game_pkg.sv
// game controller shared types: states, key events, background requests and codes
package game_pkg;

	// game states, kept in this order for the display logic
	typedef enum logic [2:0] {
		st_menu,
		st_round_paused,
		st_round_started,
		st_blue_wins,
		st_red_wins
	} game_state_t;

	// command pulses, each high for one cycle per key press
	typedef struct packed {
		logic enter;
		logic up;
		logic down;
	} key_event_t;

	// which background the loader should show
	typedef enum logic [1:0] {
		bg_map,
		bg_blue_win,
		bg_red_win,
		bg_menu
	} bg_kind_t;

	typedef struct packed {
		logic     valid;
		bg_kind_t kind;
	} bg_req_t;

	// keyboard scan codes
	localparam logic [7:0] KEY_ENTER = 8'h28;
	localparam logic [7:0] KEY_W     = 8'h1a;
	localparam logic [7:0] KEY_S     = 8'h16;
	localparam logic [7:0] KEY_UP    = 8'h52;
	localparam logic [7:0] KEY_DOWN  = 8'h51;

	// background select register in the loader
	localparam logic [11:0] BG_REG_ADDR = 12'h040;

endpackage

//--- design/game_state_fsm.sv
// game state machine: menu, rounds and win screens, with background load requests
`timescale 1ns/1ps

module game_state_fsm (
	input  logic                  Clk,
	input  logic                  rst,
	input  logic                  reset_game,
	input  logic                  reset_round,
	input  logic                  blue_win,
	input  logic                  red_win,
	input  game_pkg::key_event_t  key_event,
	output game_pkg::game_state_t game_state,
	output game_pkg::bg_req_t     bg_req
);

	game_pkg::game_state_t next_state;
	game_pkg::bg_req_t     next_req;

	always_comb
	begin
		next_state = game_state;
		next_req = '0;
		// reset_game wins over everything
		if (reset_game)
		begin
			next_state = game_pkg::st_menu;
			next_req = '{valid: 1'b1, kind: game_pkg::bg_menu};
		end
		else
		begin
			case (game_state)
				game_pkg::st_menu:
					if (key_event.enter)
					begin
						next_state = game_pkg::st_round_paused;
						next_req = '{valid: 1'b1, kind: game_pkg::bg_map};
					end
				game_pkg::st_round_paused:
					if (key_event.enter)
						next_state = game_pkg::st_round_started;
				game_pkg::st_round_started:
					// round reset first, then blue, then red
					if (reset_round)
					begin
						next_state = game_pkg::st_round_paused;
						next_req = '{valid: 1'b1, kind: game_pkg::bg_map};
					end
					else if (blue_win)
					begin
						next_state = game_pkg::st_blue_wins;
						next_req = '{valid: 1'b1, kind: game_pkg::bg_blue_win};
					end
					else if (red_win)
					begin
						next_state = game_pkg::st_red_wins;
						next_req = '{valid: 1'b1, kind: game_pkg::bg_red_win};
					end
				game_pkg::st_blue_wins,
				game_pkg::st_red_wins:
					if (key_event.enter)
					begin
						next_state = game_pkg::st_menu;
						next_req = '{valid: 1'b1, kind: game_pkg::bg_menu};
					end
				default:
					next_state = game_pkg::st_menu;
			endcase
		end
	end

	// request registered alongside the state so both appear together
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			game_state <= game_pkg::st_menu;
			bg_req <= '0;
		end
		else
		begin
			game_state <= next_state;
			bg_req <= next_req;
		end
	end

	state_legal: assert property (@(posedge Clk) disable iff (rst)
		game_state inside {game_pkg::st_menu, game_pkg::st_round_paused,
			game_pkg::st_round_started, game_pkg::st_blue_wins, game_pkg::st_red_wins});

	// a menu reload on reset_game may come while already in the menu
	req_needs_change: assert property (@(posedge Clk) disable iff (rst)
		bg_req.valid |-> (game_state != $past(game_state)) || $past(reset_game));

endmodule

//--- design/key_event_decoder.sv
// key event decoder: turns a held scan code into one-cycle enter, up and down pulses
`timescale 1ns/1ps

module key_event_decoder (
	input  logic                 Clk,
	input  logic                 rst,
	input  logic [7:0]           scan_code,
	output game_pkg::key_event_t key_event
);

	// code seen on the previous edge, for press detection
	logic [7:0]           prev_code;
	logic                 new_press;
	game_pkg::key_event_t decoded;

	assign new_press = (scan_code != prev_code);

	always_comb
	begin
		decoded = '0;
		if (new_press)
		begin
			decoded.enter = (scan_code == game_pkg::KEY_ENTER);
			// W and up arrow both move up
			decoded.up = (scan_code == game_pkg::KEY_W) ||
				(scan_code == game_pkg::KEY_UP);
			decoded.down = (scan_code == game_pkg::KEY_S) ||
				(scan_code == game_pkg::KEY_DOWN);
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			prev_code <= '0;
			key_event <= '0;
		end
		else
		begin
			prev_code <= scan_code;
			key_event <= decoded;
		end
	end

endmodule

//--- design/map_selector.sv
// map selector: picks the map in the menu, wrapping in both directions
`timescale 1ns/1ps

module map_selector #(
	parameter int unsigned NUM_MAPS = 3
) (
	input  logic                  Clk,
	input  logic                  rst,
	input  game_pkg::key_event_t  key_event,
	input  game_pkg::game_state_t game_state,
	output logic [3:0]            map_idx
);

	localparam logic [3:0] LAST_IDX = 4'(NUM_MAPS - 1);

	logic in_menu;

	assign in_menu = (game_state == game_pkg::st_menu);

	// index only moves in the menu, so the last pick carries into the next round
	always_ff @(posedge Clk)
	begin
		if (rst)
			map_idx <= '0;
		else if (in_menu)
		begin
			if (key_event.up)
			begin
				if (map_idx == LAST_IDX)
					map_idx <= '0;
				else
					map_idx <= map_idx + 4'd1;
			end
			else if (key_event.down)
			begin
				if (map_idx == 4'd0)
					map_idx <= LAST_IDX;
				else
					map_idx <= map_idx - 4'd1;
			end
		end
	end

	idx_in_range: assert property (@(posedge Clk) disable iff (rst)
		map_idx < NUM_MAPS);

endmodule

//--- filelist.f
design/game_pkg.sv
design/key_event_decoder.sv
design/game_state_fsm.sv
design/map_selector.sv
design/bg_load_requester.sv
design/game_control_top.sv
verif/game_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the game controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module game_control_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vgame_control_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

//--- verif/game_control_tb.sv
// game controller testbench: drives key and win inputs, models the APB loader, checks writes
`timescale 1ns/1ps

module game_control_tb;

	localparam int NUM_MAPS = 3;
	localparam int C_ENTER = 0;
	localparam int C_UP = 1;
	localparam int C_DOWN = 2;
	localparam int C_RROUND = 3;
	localparam int C_BLUE = 4;
	localparam int C_RED = 5;
	localparam int C_RGAME = 6;
	localparam int C_BOTH = 7;

	logic Clk = 1'b0;
	logic rst = 1'b1;
	logic reset_game = 1'b0;
	logic reset_round = 1'b0;
	logic blue_win = 1'b0;
	logic red_win = 1'b0;
	logic [7:0] scan_code = 8'h00;
	logic pready = 1'b0;
	logic pslverr = 1'b0;
	game_pkg::game_state_t game_state;
	logic [11:0] paddr;
	logic psel, penable, pwrite;
	logic [3:0] pwdata;
	logic [7:0] err_count;

	int exp_q[$];
	int got_q[$];
	int errors = 0, err_at_start = 0, tests_run = 0, tests_failed = 0;
	int writes_seen = 0, wait_left = 0, m_state = 0, m_idx = 0;
	int n_keys, n, writes_before;
	bit hold_ready = 1'b0;
	bit inject_err = 1'b0;
	logic [11:0] xfer_addr;
	logic [3:0] xfer_data;
	string test_name = "none";

	game_control_top #(.NUM_MAPS(NUM_MAPS)) UUT (.Clk(Clk), .rst(rst), .reset_game(reset_game),
		.reset_round(reset_round), .blue_win(blue_win), .red_win(red_win),
		.scan_code(scan_code), .game_state(game_state), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .pready(pready),
		.pslverr(pslverr), .err_count(err_count));

	always #5 Clk = ~Clk;

	// expected background index for a command, or -1 when no load is due
	function automatic int model_step(input int cmd);
		int want;
		want = -1;
		if (cmd == C_RGAME)
		begin
			m_state = 0;
			want = NUM_MAPS + 2;
		end
		else if (m_state == 0)
		begin
			if (cmd == C_UP)
				m_idx = (m_idx + 1) % NUM_MAPS;
			else if (cmd == C_DOWN)
				m_idx = (m_idx + NUM_MAPS - 1) % NUM_MAPS;
			else if (cmd == C_ENTER)
			begin
				m_state = 1;
				want = m_idx;
			end
		end
		else if (m_state == 1 && cmd == C_ENTER)
			m_state = 2;
		else if (m_state == 2)
		begin
			// round reset beats a win, blue beats red
			if (cmd == C_RROUND)
			begin
				m_state = 1;
				want = m_idx;
			end
			else if (cmd == C_BLUE || cmd == C_BOTH)
			begin
				m_state = 3;
				want = NUM_MAPS;
			end
			else if (cmd == C_RED)
			begin
				m_state = 4;
				want = NUM_MAPS + 1;
			end
		end
		else if (m_state >= 3 && cmd == C_ENTER)
		begin
			m_state = 0;
			want = NUM_MAPS + 2;
		end
		return want;
	endfunction

	// loader: random wait states, stability checks, records each finished write
	always @(posedge Clk)
	begin
		if (!rst && psel)
		begin
			if (!penable)
			begin
				xfer_addr = paddr;
				xfer_data = pwdata;
				wait_left = int'($urandom % 4);
				if (paddr != game_pkg::BG_REG_ADDR)
				begin
					errors++;
					$display("FAIL %s paddr: expected %0h, actual %0h", test_name,
						game_pkg::BG_REG_ADDR, paddr);
				end
				if (!pwrite)
				begin
					errors++;
					$display("read transfer instead of a write in test %s", test_name);
				end
			end
			else
			begin
				if (paddr != xfer_addr)
				begin
					errors++;
					$display("FAIL %s stable paddr: expected %0h, actual %0h", test_name,
						xfer_addr, paddr);
				end
				if (pwdata != xfer_data)
				begin
					errors++;
					$display("FAIL %s stable pwdata: expected %0d, actual %0d", test_name,
						xfer_data, pwdata);
				end
			end
			if (penable && pready)
			begin
				got_q.push_back(int'(pwdata));
				writes_seen++;
				if (pslverr)
					inject_err = 1'b0;
			end
			else if (penable && wait_left != 0)
				wait_left--;
		end
		#1;
		pready = !hold_ready && (wait_left == 0);
		pslverr = inject_err;
	end

	// compare finished writes against the model
	always @(negedge Clk)
	begin
		int got;
		int want;
		while (got_q.size() > 0)
		begin
			got = got_q.pop_front();
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("unexpected write of %0d in test %s", got, test_name);
			end
			else
			begin
				want = exp_q.pop_front();
				if (want != got)
				begin
					errors++;
					$display("FAIL %s write: expected %0d, actual %0d", test_name, want, got);
				end
			end
		end
	end

	task tick;
		@(posedge Clk);
		#1;
	endtask

	task press_key(input logic [7:0] code, input int hold);
		scan_code = code;
		repeat (hold) tick;
		scan_code = 8'h00;
		tick;
	endtask

	task pulse_level(input int cmd);
		reset_round = (cmd == C_RROUND);
		blue_win = (cmd == C_BLUE) || (cmd == C_BOTH);
		red_win = (cmd == C_RED) || (cmd == C_BOTH);
		reset_game = (cmd == C_RGAME);
		tick;
		reset_round = 1'b0;
		blue_win = 1'b0;
		red_win = 1'b0;
		reset_game = 1'b0;
	endtask

	// wait until the bus is idle and every expected write has arrived
	task wait_idle;
		n = 0;
		while ((exp_q.size() != 0 || psel) && n < 200)
		begin
			tick;
			n++;
		end
		if (exp_q.size() != 0 || psel)
		begin
			errors++;
			$display("timeout with expected writes still missing in test %s", test_name);
		end
	endtask

	task apply_cmd(input int cmd, input int hold, input bit keep);
		int want;
		// earlier writes drain first unless the bus is stalled on purpose
		if (!hold_ready)
			wait_idle;
		want = model_step(cmd);
		if (want >= 0 && keep)
			exp_q.push_back(want);
		case (cmd)
			C_ENTER: press_key(game_pkg::KEY_ENTER, hold);
			C_UP: press_key(($urandom % 2 == 0) ? game_pkg::KEY_W : game_pkg::KEY_UP, hold);
			C_DOWN: press_key(($urandom % 2 == 0) ? game_pkg::KEY_S : game_pkg::KEY_DOWN, hold);
			default: pulse_level(cmd);
		endcase
		if (int'(game_state) != m_state)
		begin
			errors++;
			$display("FAIL %s state: expected %0d, actual %0d", test_name, m_state,
				int'(game_state));
		end
	endtask

	task wait_psel;
		n = 0;
		while (!psel && n < 200)
		begin
			tick;
			n++;
		end
		if (!psel)
		begin
			errors++;
			$display("timeout waiting for psel in test %s", test_name);
		end
	endtask

	task start_test(input string name);
		test_name = name;
		err_at_start = errors;
		tests_run++;
	endtask

	// wait for outstanding writes, then allow time for stray ones
	task end_test;
		wait_idle;
		repeat (10) tick;
		if (errors == err_at_start)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - err_at_start);
		end
	endtask

	initial
	begin
		void'($urandom(32'h70c71bb3));
		repeat (8) @(posedge Clk);
		#1;
		rst = 1'b0;

		start_test("reset");
		if (psel || penable || int'(game_state) != 0)
		begin
			errors++;
			$display("bus active or state not menu after reset");
		end
		repeat (20) tick;
		if (writes_seen != 0)
		begin
			errors++;
			$display("a write happened right after reset");
		end
		end_test;

		start_test("menu navigation");
		n_keys = 3 + int'($urandom % 6);
		repeat (n_keys) apply_cmd(($urandom % 2 == 0) ? C_UP : C_DOWN, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		end_test;

		start_test("round flow");
		apply_cmd(C_ENTER, 30, 1'b1);
		apply_cmd(C_RROUND, 1, 1'b1);
		end_test;

		start_test("wins");
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_BLUE, 1, 1'b1);
		// held enter must not run on from the menu into a round
		apply_cmd(C_ENTER, 30, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_RED, 1, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_BOTH, 1, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		end_test;

		start_test("back-pressure");
		hold_ready = 1'b1;
		tick;
		writes_before = writes_seen;
		apply_cmd(C_RROUND, 1, 1'b1);
		wait_psel;
		apply_cmd(C_ENTER, 2, 1'b0);
		// overwritten in the pending slot by the win below
		apply_cmd(C_RROUND, 1, 1'b0);
		apply_cmd(C_ENTER, 2, 1'b0);
		apply_cmd(C_BLUE, 1, 1'b1);
		repeat (5) tick;
		if (writes_seen != writes_before)
		begin
			errors++;
			$display("a write finished while pready was held low");
		end
		hold_ready = 1'b0;
		end_test;

		start_test("reset game");
		inject_err = 1'b1;
		apply_cmd(C_RGAME, 1, 1'b1);
		wait_idle;
		// one error response so far
		if (int'(err_count) != 1)
		begin
			errors++;
			$display("FAIL %s err_count: expected %0d, actual %0d", test_name, 1,
				err_count);
		end
		apply_cmd(C_RGAME, 1, 1'b1);
		apply_cmd(C_ENTER, 2, 1'b1);
		apply_cmd(C_RGAME, 1, 1'b1);
		end_test;

		$display("tests run %0d, tests failed %0d, failed checks %0d", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
